// ==== files.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/fpu.sv
rtl/execution.sv
bench/execution_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module execution_tb -o execution_sim

sim_output=$(./obj_dir/execution_sim)
echo "$sim_output"

if grep -qx "TESTBENCH PASSED" <<< "$sim_output"; then
	exit 0
else
	exit 1
fi

// ==== bench/exec_tests.txt ====
# rw m2r mw mr u2r br index pc1 fp op1 op2 dst op rs_val rt_val rt rd sh imm pc, all hex
# then the expected result, dest, branch_target and store_data
1 0 0 0 0 3 0000001 11 0 0 0 0 0 00000005 00000007 02 03 00 0000 10 0000000c 03 11 00000007
1 0 0 0 0 3 0000002 12 0 0 0 0 1 00000003 00000005 02 04 00 0010 11 fffffffe 04 22 00000005
1 0 0 0 0 3 0000003 13 0 0 0 0 2 f0f0f0f0 ff00ff00 02 05 00 0000 12 f000f000 05 13 ff00ff00
1 0 0 0 0 3 0000004 14 1 0 0 0 c 3f800000 40000000 02 06 00 0000 13 40400000 06 14 40000000
1 0 0 0 0 3 0000005 15 0 0 0 0 3 12340000 00005678 02 07 00 00f0 14 12345678 07 05 00005678
1 0 0 0 0 3 0000006 16 1 0 0 0 d 3fc00000 3fa00000 02 08 00 0000 15 3e800000 08 16 3fa00000
1 0 0 0 0 3 0000007 17 0 0 0 0 4 aaaa5555 ffff0000 02 09 00 0001 16 55555555 09 18 ffff0000
1 0 0 0 0 3 0000008 18 0 0 0 0 5 0000ffff 00ff0000 02 0a 00 0000 17 ff000000 0a 18 00ff0000
1 0 0 0 0 3 0000009 19 1 0 0 0 d 3f800001 3f800000 02 0b 00 0000 18 34000000 0b 19 3f800000
1 0 0 0 0 3 000000a 1a 1 0 0 0 c 00000000 40200000 02 0c 00 0000 19 40200000 0c 1a 40200000
1 0 0 0 0 3 000000b 1b 0 0 0 0 6 ffffffff 00000001 02 0d 00 0000 1a 00000001 0d 1b 00000001
1 0 0 0 0 3 000000c 1c 0 0 0 0 7 ffffffff 00000001 02 0e 00 0000 1b 00000000 0e 1c 00000001
1 0 0 0 0 3 000000d 1d 1 0 0 0 c 40400000 c0400000 02 0f 00 0000 1c 00000000 0f 1d c0400000
1 0 0 0 0 3 000000e 1e 0 1 1 0 8 deadbeef 00000081 02 10 04 0000 1d 00000810 10 1e 00000081
1 0 0 0 0 3 000000f 1f 0 1 1 0 9 deadbeef 80000000 02 11 1f 0000 1e 00000001 11 1f 80000000
1 0 0 0 0 3 0000010 20 0 1 1 0 a deadbeef 80000000 02 12 08 0000 1f ff800000 12 20 80000000
1 0 0 0 0 3 0000011 21 1 0 0 0 e 3fc00000 40000000 02 13 00 0000 20 40400000 13 21 40000000
1 0 0 0 0 3 0000012 22 1 0 0 0 e 3fc00000 3fc00000 02 14 00 0000 21 40100000 14 22 3fc00000
1 0 0 0 0 3 0000013 23 0 0 2 1 0 00000010 11111111 0e 00 00 fffc 22 0000000c 0e 1f 11111111
1 0 0 0 0 3 0000014 24 0 0 3 1 3 00010000 22222222 0f 00 00 8001 23 00018001 0f 25 22222222
1 0 0 0 0 3 0000015 25 0 0 3 1 b 00000000 33333333 10 00 00 1234 24 12340000 10 59 33333333
1 0 0 0 0 3 0000016 26 1 0 0 0 e 00800000 3f000000 02 15 00 0000 25 00000000 15 26 3f000000
1 0 0 0 0 3 0000017 27 0 0 2 1 6 fffffffe 44444444 11 00 00 ffff 26 00000001 11 26 44444444
1 0 0 0 0 3 0000018 28 1 0 0 0 e c0000000 40400000 02 16 00 0000 27 c0c00000 16 28 40400000
0 0 1 0 0 3 0000019 29 0 0 2 1 0 00000040 cafef00d 13 00 00 0008 28 00000048 13 31 cafef00d
1 1 0 1 0 3 000001a 2a 0 0 2 1 0 00000040 00000000 14 00 00 fff8 29 00000038 14 22 00000000
1 0 0 0 0 3 000001b 2b 1 0 0 0 e 3f800001 3fc00000 02 17 00 0000 2a 3fc00001 17 2b 3fc00000
1 0 0 0 0 2 0abcdef 2c 0 0 0 2 0 00000030 00000000 00 00 00 0000 2b 00000030 1f 2c 00000000
0 0 0 0 0 0 000001d 2d 0 0 0 0 1 00000009 00000009 09 00 00 0005 2c 00000000 00 32 00000009
1 0 0 0 0 3 000001e 2e 1 0 0 0 c 3f800000 3f800001 02 18 00 0000 2d 40000000 18 2e 3f800001
0 0 0 0 0 1 000001f 2f 0 0 0 0 1 00000001 00000002 02 00 00 fff0 2e ffffffff 00 1f 00000002
1 0 0 0 0 3 0000020 30 1 0 0 0 d 3f800000 40000000 02 19 00 0000 2f bf800000 19 30 40000000
1 2 0 0 1 3 3ffffff 31 0 0 0 0 0 00000000 00000000 02 15 00 0000 30 00000000 15 31 00000000

// ==== bench/execution_tb.sv ====
module execution_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_COLUMNS    = 24;
	localparam int CYCLES_PER_VEC = 40;
	localparam int TIMEOUT_SLACK  = 100;
	localparam int RESET_CYCLES   = 8;
	localparam int DRIVE_DELAY    = 5;

	// One instruction waiting for its result.
	typedef struct packed {
		pipe_pkg::exec_result_t exp;
		int                     index;
		int                     ack_cycle;
	} pending_t;

	logic                   CLK;
	logic                   reset;
	pipe_pkg::issue_t       issue;
	logic                   issue_req;
	logic                   issue_ack;
	pipe_pkg::exec_result_t result;
	logic                   result_valid;

	pipe_pkg::issue_t       issue_vecs[$];
	pipe_pkg::exec_result_t expect_vecs[$];
	pending_t               pending_q[$];

	int cycle_count     = 0;
	int cycle_limit     = 0;
	int results_seen    = 0;
	int mismatch_count  = 0;
	int handshake_count = 0;
	int other_count     = 0;

	execution execution_inst (
		.CLK          (CLK),
		.reset        (reset),
		.issue        (issue),
		.issue_req    (issue_req),
		.issue_ack    (issue_ack),
		.result       (result),
		.result_valid (result_valid)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#50 CLK = 1'b1;
			#50 CLK = 1'b0;
		end
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic next_cycle();
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	task automatic load_vectors();
		int                     fd;
		int                     n;
		int                     line_no;
		string                  line;
		logic [31:0]            col [NUM_COLUMNS];
		pipe_pkg::issue_t       iss;
		pipe_pkg::exec_result_t exp;
		fd = $fopen("bench/exec_tests.txt", "r");
		if (fd == 0) begin
			other_count++;
			$display("Cannot open the test vector file bench/exec_tests.txt");
			return;
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line_no++;
			n = $fgets(line, fd);
			if (n <= 1 || line.getc(0) == "#")
				continue;
			n = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
				col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
			if (n != NUM_COLUMNS) begin
				other_count++;
				$display("Malformed vector on line %0d of the test file", line_no);
				continue;
			end
			iss.pass.reg_write   = col[0][0];
			iss.pass.mem_to_reg  = col[1][1:0];
			iss.pass.mem_write   = col[2][0];
			iss.pass.mem_read    = col[3][0];
			iss.pass.uart_to_reg = col[4][0];
			iss.pass.branch      = isa_pkg::branch_e'(col[5][1:0]);
			iss.pass.inst_index  = col[6][isa_pkg::INDEX_WIDTH-1:0];
			iss.pass.pc1         = col[7][isa_pkg::PC_WIDTH-1:0];
			iss.is_fp            = col[8][0];
			iss.op1_src          = isa_pkg::op1_src_e'(col[9][0]);
			iss.op2_src          = isa_pkg::op2_src_e'(col[10][1:0]);
			iss.dest_src         = isa_pkg::dest_src_e'(col[11][1:0]);
			iss.alu_op           = isa_pkg::alu_op_e'(col[12][3:0]);
			iss.rs_val           = col[13];
			iss.rt_val           = col[14];
			iss.rt               = col[15][4:0];
			iss.rd               = col[16][4:0];
			iss.shamt            = col[17][4:0];
			iss.imm16            = col[18][15:0];
			iss.pc               = col[19][isa_pkg::PC_WIDTH-1:0];
			// Control fields pass through unchanged.
			exp.pass             = iss.pass;
			exp.is_fp            = iss.is_fp;
			exp.result           = col[20];
			exp.dest             = col[21][4:0];
			exp.branch_target    = col[22][isa_pkg::PC_WIDTH-1:0];
			exp.store_data       = col[23];
			issue_vecs.push_back(iss);
			expect_vecs.push_back(exp);
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	task automatic check_result(
		input pipe_pkg::exec_result_t got,
		input pipe_pkg::exec_result_t exp,
		input string                  what
	);
		if (got.pass !== exp.pass) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s pass fields %h, expected %h", $time, what,
				got.pass, exp.pass);
		end
		if (got.is_fp !== exp.is_fp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is_fp %b, expected %b", $time, what,
				got.is_fp, exp.is_fp);
		end
		if (got.result !== exp.result) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s result %h, expected %h", $time, what,
				got.result, exp.result);
		end
		if (got.store_data !== exp.store_data) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s store_data %h, expected %h", $time, what,
				got.store_data, exp.store_data);
		end
		if (got.dest !== exp.dest) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s dest %h, expected %h", $time, what,
				got.dest, exp.dest);
		end
		if (got.branch_target !== exp.branch_target) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s branch_target %h, expected %h", $time, what,
				got.branch_target, exp.branch_target);
		end
	endtask

	task automatic check_ack(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			handshake_count++;
			$display("Handshake violation at %0t: %s", $time, what);
		end
	endtask

	// ----------------------------------------
	// Issue side
	// ----------------------------------------
	task automatic send_issue(input int idx, input bit after_fp);
		int       gap;
		int       hold;
		pending_t p;
		// Right behind an FP op the request goes up at once.
		gap  = after_fp ? 0 : int'($urandom % 4);
		hold = int'($urandom % 2);
		repeat (gap) next_cycle();
		issue     = issue_vecs[idx];
		issue_req = 1'b1;
		next_cycle();
		while (issue_ack !== 1'b1)
			next_cycle();
		if (pending_q.size() != 0) begin
			handshake_count++;
			$display("Handshake violation at %0t: vector %0d taken before the previous result",
				$time, idx);
		end
		p.exp       = expect_vecs[idx];
		p.index     = idx;
		p.ack_cycle = cycle_count;
		pending_q.push_back(p);
		repeat (hold) begin
			next_cycle();
			check_ack(issue_ack, 1'b1, "ack fell while req was still high");
		end
		issue_req = 1'b0;
		next_cycle();
		check_ack(issue_ack, 1'b0, "ack stayed high after req fell");
	endtask

	task automatic take_result();
		pending_t p;
		if (pending_q.size() == 0) begin
			other_count++;
			$display("Result valid at %0t with no instruction outstanding", $time);
			return;
		end
		p = pending_q.pop_front();
		results_seen++;
		check_result(result, p.exp, $sformatf("vector %0d", p.index));
		if (!p.exp.is_fp && cycle_count != p.ack_cycle + 1) begin
			mismatch_count++;
			$display("Mismatch at %0t: vector %0d valid %0d cycles after ack, expected 1",
				$time, p.index, cycle_count - p.ack_cycle);
		end
	endtask

	// Result monitor.
	initial begin
		forever begin
			next_cycle();
			if (!reset && result_valid)
				take_result();
		end
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit)
			@(posedge CLK);
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		bit                     prev_fp;
		pipe_pkg::exec_result_t reset_exp;
		void'($urandom(32'h70b0_834e));
		reset      = 1'b1;
		issue_req  = 1'b0;
		issue      = '0;
		load_vectors();
		cycle_limit = issue_vecs.size() * CYCLES_PER_VEC + TIMEOUT_SLACK;
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DELAY;
		reset = 1'b0;
		next_cycle();

		reset_exp             = '0;
		reset_exp.pass.branch = isa_pkg::BR_NONE;
		check_ack(issue_ack, 1'b0, "ack is high after reset");
		if (result_valid !== 1'b0) begin
			other_count++;
			$display("Result valid is high after reset");
		end
		check_result(result, reset_exp, "after reset");

		prev_fp = 1'b0;
		for (int i = 0; i < issue_vecs.size(); i++) begin
			send_issue(i, prev_fp);
			prev_fp = issue_vecs[i].is_fp;
		end
		while (pending_q.size() != 0)
			next_cycle();
		// A few more cycles to catch a stray valid.
		repeat (4) next_cycle();
		if (results_seen != issue_vecs.size()) begin
			other_count++;
			$display("Saw %0d results for %0d instructions", results_seen, issue_vecs.size());
		end

		$display("Errors: %0d mismatch, %0d handshake, %0d other",
			mismatch_count, handshake_count, other_count);
		if (mismatch_count + handshake_count + other_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== rtl/execution.sv ====
module execution (
	input  logic                     CLK,
	input  logic                     reset,
	input  pipe_pkg::issue_t         issue,
	input  logic                     issue_req,
	output logic                     issue_ack,
	output pipe_pkg::exec_result_t   result,
	output logic                     result_valid
);

	typedef enum logic [1:0] {IDLE, INT_EXEC, FP_WAIT} state_e;

	state_e                            state;
	pipe_pkg::issue_t                  instr;
	logic                              accept;
	logic [isa_pkg::DATA_WIDTH-1:0]    op1;
	logic [isa_pkg::DATA_WIDTH-1:0]    op2;
	logic [isa_pkg::DATA_WIDTH-1:0]    alu_y;
	logic [isa_pkg::DATA_WIDTH-1:0]    fpu_y;
	isa_pkg::reg_addr_t                dest;
	logic [isa_pkg::PC_WIDTH-1:0]      branch_target;
	logic                              fpu_start;
	logic                              fpu_done;
	pipe_pkg::exec_result_t            result_next;

	// New work only when idle and the last handshake has closed.
	assign accept = issue_req && !issue_ack && (state == IDLE);

	operand_select operand_select_inst (
		.instr         (instr),
		.op1           (op1),
		.op2           (op2),
		.dest          (dest),
		.branch_target (branch_target)
	);

	alu alu_inst (
		.op (instr.alu_op),
		.a  (op1),
		.b  (op2),
		.y  (alu_y)
	);

	fpu fpu_inst (
		.CLK   (CLK),
		.reset (reset),
		.start (fpu_start),
		.op    (instr.alu_op),
		.a     (op1),
		.b     (op2),
		.done  (fpu_done),
		.y     (fpu_y)
	);

	always_comb begin
		result_next.pass          = instr.pass;
		result_next.is_fp         = instr.is_fp;
		result_next.result        = instr.is_fp ? fpu_y : alu_y;
		result_next.store_data    = instr.rt_val;
		result_next.dest          = dest;
		result_next.branch_target = branch_target;
	end

	// Held until the result is out.
	always_ff @(posedge CLK) begin
		if (accept)
			instr <= issue;
	end

	// ----------------------------------------
	// Handshake and stage FSM
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			state              <= IDLE;
			issue_ack          <= 1'b0;
			fpu_start          <= 1'b0;
			result_valid       <= 1'b0;
			result             <= '0;
			result.pass.branch <= isa_pkg::BR_NONE;
		end else begin
			result_valid <= 1'b0;
			fpu_start    <= 1'b0;
			if (accept)
				issue_ack <= 1'b1;
			else if (issue_ack && !issue_req)
				issue_ack <= 1'b0;
			unique case (state)
				IDLE: begin
					if (accept) begin
						state     <= issue.is_fp ? FP_WAIT : INT_EXEC;
						fpu_start <= issue.is_fp;
					end
				end
				INT_EXEC: begin
					result       <= result_next;
					result_valid <= 1'b1;
					state        <= IDLE;
				end
				default: begin
					if (fpu_done) begin
						result       <= result_next;
						result_valid <= 1'b1;
						state        <= IDLE;
					end
				end
			endcase
		end
	end

	// One FPU answer per FP instruction in flight.
	assert property (@(posedge CLK) disable iff (reset) fpu_done |-> state == FP_WAIT);

	// Decode holds the instruction until it is taken.
	assert property (@(posedge CLK) disable iff (reset)
		issue_req && !issue_ack |=> issue_ack || $stable(issue));

endmodule

// ==== rtl/fpu.sv ====
module fpu (
	input  logic                               CLK,
	input  logic                               reset,
	input  logic                               start,
	input  isa_pkg::alu_op_e                   op,
	input  logic [isa_pkg::DATA_WIDTH-1:0]     a,
	input  logic [isa_pkg::DATA_WIDTH-1:0]     b,
	output logic                               done,
	output logic [isa_pkg::DATA_WIDTH-1:0]     y
);

	typedef enum logic [2:0] {IDLE, UNPACK, ALIGN_MUL, NORMALIZE, PACK} state_e;

	state_e             state;
	logic               sign_a;
	logic               sign_b;
	logic [7:0]         exp_a;
	logic [7:0]         exp_b;
	logic [23:0]        man_a;
	logic [23:0]        man_b;
	logic               sign_r;
	logic signed [9:0]  exp_r;
	logic [24:0]        man_r;

	logic               eff_sign_b;
	logic [7:0]         shift_amt;
	logic [7:0]         big_e;
	logic [23:0]        big_m;
	logic [23:0]        small_m;
	logic               big_s;
	logic               small_s;
	logic [24:0]        add_sum;
	logic               add_sign;
	logic [47:0]        product;
	logic signed [9:0]  mul_exp;

	// ----------------------------------------
	// Align and add, or multiply
	// ----------------------------------------
	always_comb begin
		eff_sign_b = sign_b ^ (op == isa_pkg::ALU_FSUB);
		if (exp_a >= exp_b) begin
			shift_amt = exp_a - exp_b;
			big_e     = exp_a;
			big_m     = man_a;
			big_s     = sign_a;
			small_m   = man_b >> shift_amt;
			small_s   = eff_sign_b;
		end else begin
			shift_amt = exp_b - exp_a;
			big_e     = exp_b;
			big_m     = man_b;
			big_s     = eff_sign_b;
			small_m   = man_a >> shift_amt;
			small_s   = sign_a;
		end
		// Magnitude subtract keeps the sign of the larger one.
		if (big_s == small_s) begin
			add_sum  = {1'b0, big_m} + {1'b0, small_m};
			add_sign = big_s;
		end else if (big_m >= small_m) begin
			add_sum  = {1'b0, big_m - small_m};
			add_sign = big_s;
		end else begin
			add_sum  = {1'b0, small_m - big_m};
			add_sign = small_s;
		end
		product = man_a * man_b;
		mul_exp = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'sd127;
	end

	// ----------------------------------------
	// Control
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			unique case (state)
				IDLE:      if (start) state <= UNPACK;
				UNPACK:    state <= ALIGN_MUL;
				ALIGN_MUL: state <= NORMALIZE;
				NORMALIZE: if (man_r[24] || man_r[23] || man_r == '0) state <= PACK;
				default: begin
					done  <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------
	// Datapath
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		unique case (state)
			UNPACK: begin
				sign_a <= a[31];
				sign_b <= b[31];
				exp_a  <= a[30:23];
				exp_b  <= b[30:23];
				// Zero exponent means zero, no denormals.
				man_a  <= (a[30:23] == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
				man_b  <= (b[30:23] == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
			end
			ALIGN_MUL: begin
				if (op == isa_pkg::ALU_FMUL) begin
					sign_r <= sign_a ^ sign_b;
					exp_r  <= mul_exp;
					man_r  <= product[47:23];
				end else begin
					sign_r <= add_sign;
					exp_r  <= $signed({2'b00, big_e});
					man_r  <= add_sum;
				end
			end
			NORMALIZE: begin
				if (man_r[24]) begin
					man_r <= man_r >> 1;
					exp_r <= exp_r + 10'sd1;
				end else if (!man_r[23] && man_r != '0) begin
					man_r <= man_r << 1;
					exp_r <= exp_r - 10'sd1;
				end
			end
			PACK: begin
				// Zero mantissa or underflow flushes to +0.
				if (!man_r[23] || exp_r < 10'sd1)
					y <= '0;
				else
					y <= {sign_r, exp_r[7:0], man_r[22:0]};
			end
			default: ;
		endcase
	end

	// Stage must hold off until the previous op is done.
	assert property (@(posedge CLK) disable iff (reset) start |-> state == IDLE);

endmodule

// ==== rtl/alu.sv ====
module alu (
	input  isa_pkg::alu_op_e                   op,
	input  logic [isa_pkg::DATA_WIDTH-1:0]     a,
	input  logic [isa_pkg::DATA_WIDTH-1:0]     b,
	output logic [isa_pkg::DATA_WIDTH-1:0]     y
);

	logic [isa_pkg::SHAMT_WIDTH-1:0] sh;
	logic                            lt_signed;
	logic                            lt_unsigned;

	assign sh          = b[isa_pkg::SHAMT_WIDTH-1:0];
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		unique case (op)
			isa_pkg::ALU_ADD:  y = a + b;
			isa_pkg::ALU_SUB:  y = a - b;
			isa_pkg::ALU_AND:  y = a & b;
			isa_pkg::ALU_OR:   y = a | b;
			isa_pkg::ALU_XOR:  y = a ^ b;
			isa_pkg::ALU_NOR:  y = ~(a | b);
			isa_pkg::ALU_SLT:
				y = {{(isa_pkg::DATA_WIDTH-1){1'b0}}, lt_signed};
			isa_pkg::ALU_SLTU:
				y = {{(isa_pkg::DATA_WIDTH-1){1'b0}}, lt_unsigned};
			isa_pkg::ALU_SLL:  y = a << sh;
			isa_pkg::ALU_SRL:  y = a >> sh;
			isa_pkg::ALU_SRA:  y = $signed(a) >>> sh;
			// Upper half load from the immediate.
			isa_pkg::ALU_LUI:  y = b << 16;
			// FP codes go to the FPU.
			default:           y = '0;
		endcase
	end

endmodule

// ==== rtl/operand_select.sv ====
module operand_select (
	input  pipe_pkg::issue_t                   instr,
	output logic [isa_pkg::DATA_WIDTH-1:0]     op1,
	output logic [isa_pkg::DATA_WIDTH-1:0]     op2,
	output isa_pkg::reg_addr_t                 dest,
	output logic [isa_pkg::PC_WIDTH-1:0]       branch_target
);

	// First operand.
	always_comb begin
		unique case (instr.op1_src)
			isa_pkg::OP1_REG_T: op1 = instr.rt_val;
			default:            op1 = instr.rs_val;
		endcase
	end

	// Second operand, register or extended field.
	always_comb begin
		unique case (instr.op2_src)
			isa_pkg::OP2_SHAMT:
				op2 = {{(isa_pkg::DATA_WIDTH - isa_pkg::SHAMT_WIDTH){1'b0}}, instr.shamt};
			isa_pkg::OP2_IMM_SIGN:
				op2 = {{(isa_pkg::DATA_WIDTH - isa_pkg::IMM_WIDTH){instr.imm16[isa_pkg::IMM_WIDTH-1]}},
					instr.imm16};
			isa_pkg::OP2_IMM_ZERO:
				op2 = {{(isa_pkg::DATA_WIDTH - isa_pkg::IMM_WIDTH){1'b0}}, instr.imm16};
			default:
				op2 = instr.rt_val;
		endcase
	end

	// Destination register.
	always_comb begin
		unique case (instr.dest_src)
			isa_pkg::DEST_RT:   dest = instr.rt;
			isa_pkg::DEST_LINK: dest = isa_pkg::LINK_REG;
			default:            dest = instr.rd;
		endcase
	end

	// Branch target wraps within the instruction memory.
	assign branch_target = instr.pass.pc1 + instr.imm16[isa_pkg::PC_WIDTH-1:0];

endmodule

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

	// Carried through the stage untouched.
	typedef struct packed {
		logic                                reg_write;
		logic [1:0]                          mem_to_reg;
		logic                                mem_write;
		logic                                mem_read;
		logic                                uart_to_reg;
		isa_pkg::branch_e                    branch;
		logic [isa_pkg::INDEX_WIDTH-1:0]     inst_index;
		logic [isa_pkg::PC_WIDTH-1:0]        pc1;
	} pass_ctrl_t;

	// ----------------------------------------
	// Decode to execute
	// ----------------------------------------
	typedef struct packed {
		pass_ctrl_t                          pass;
		logic                                is_fp;
		isa_pkg::op1_src_e                   op1_src;
		isa_pkg::op2_src_e                   op2_src;
		isa_pkg::dest_src_e                  dest_src;
		isa_pkg::alu_op_e                    alu_op;
		logic [isa_pkg::DATA_WIDTH-1:0]      rs_val;
		logic [isa_pkg::DATA_WIDTH-1:0]      rt_val;
		isa_pkg::reg_addr_t                  rt;
		isa_pkg::reg_addr_t                  rd;
		logic [isa_pkg::SHAMT_WIDTH-1:0]     shamt;
		logic [isa_pkg::IMM_WIDTH-1:0]       imm16;
		logic [isa_pkg::PC_WIDTH-1:0]        pc;
	} issue_t;

	// ----------------------------------------
	// Execute to memory
	// ----------------------------------------
	typedef struct packed {
		pass_ctrl_t                          pass;
		logic                                is_fp;
		logic [isa_pkg::DATA_WIDTH-1:0]      result;
		logic [isa_pkg::DATA_WIDTH-1:0]      store_data;
		isa_pkg::reg_addr_t                  dest;
		logic [isa_pkg::PC_WIDTH-1:0]        branch_target;
	} exec_result_t;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	// ----------------------------------------
	// Field widths
	// ----------------------------------------
	localparam int PC_WIDTH       = 8;
	localparam int DATA_WIDTH     = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int SHAMT_WIDTH    = 5;
	localparam int IMM_WIDTH      = 16;
	localparam int INDEX_WIDTH    = 26;

	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

	// Return-address register for links.
	localparam reg_addr_t LINK_REG = 5'd31;

	// ----------------------------------------
	// Encodings
	// ----------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
		ALU_FADD, ALU_FSUB, ALU_FMUL
	} alu_op_e;

	// Shifts take their source from rt.
	typedef enum logic {OP1_REG_S, OP1_REG_T} op1_src_e;

	typedef enum logic [1:0] {OP2_REG_T, OP2_SHAMT, OP2_IMM_SIGN, OP2_IMM_ZERO} op2_src_e;

	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_src_e;

	// NONE is the idle encoding seen after reset.
	typedef enum logic [1:0] {BR_BEQ, BR_BNE, BR_JUMP, BR_NONE} branch_e;

endpackage
